// File: capture_macros.svh
/*
 * Capture unit sizing shared by the package and the RTL
 * Channel count, buffer address width and sample width
 */
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// Number of sample channels behind the shared strobe
`define CAP_CHANNELS 4

// Buffer address width, the depth of each circular buffer is two to this power
`define CAP_ADDR_WIDTH 6

// Width of one signed ADC sample
`define CAP_SAMPLE_WIDTH 16

`endif

// File: capture_pkg.sv
/*
 * Capture unit types
 * Sample, address and channel vectors plus the buffer FSM encoding
 */
`default_nettype none

`include "capture_macros.svh"

package capture_pkg;

    // One signed sample as delivered by the ADC
    typedef logic signed [`CAP_SAMPLE_WIDTH-1:0] sample_t;

    // Buffer address, also used for window length and trigger position
    typedef logic [`CAP_ADDR_WIDTH-1:0] addr_t;

    // A single channel still needs one bit of index
    localparam int CHANNEL_BITS = (`CAP_CHANNELS > 1) ? $clog2(`CAP_CHANNELS) : 1;

    typedef logic [CHANNEL_BITS-1:0] channel_t;

    typedef enum logic [2:0] {
        initial_fill,
        armed,
        acquisition,
        full,
        readout,
        refresh
    } buffer_state_t;

endpackage

`default_nettype wire

// File: trigger_detect.sv
/*
 * Trigger detector
 * Flags a rising crossing of the level on the selected channel once all buffers are armed
 */
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module trigger_detect (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        sample_valid,
    input  capture_pkg::sample_t [`CAP_CHANNELS-1:0]    sample_data,
    input  capture_pkg::channel_t                       trigger_channel,
    input  capture_pkg::sample_t                        trigger_level,
    input  logic                                        all_armed,
    output logic                                        trigger
);

    import capture_pkg::*;

    sample_t selected_sample;
    sample_t previous_sample;
    logic    below_before;
    logic    at_or_above_now;

    // Slice of the channel that the trigger watches
    assign selected_sample = sample_data[trigger_channel];

    // The history follows every strobe so that the first armed sample
    // already has a valid predecessor to compare with
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            previous_sample <= '0;
        end else if (sample_valid) begin
            previous_sample <= selected_sample;
        end
    end

    // Both compares are signed since sample_t is a signed type
    assign below_before    = previous_sample < trigger_level;
    assign at_or_above_now = selected_sample >= trigger_level;

    // Combinational on the strobe cycle so the trigger sample itself
    // lands at the trigger position of the window
    assign trigger = sample_valid && all_armed && below_before && at_or_above_now;

endmodule

`default_nettype wire

// File: capture_memory.sv
/*
 * Capture sample RAM
 * One write port and one registered read port with a read enable
 */
`timescale 1ns/1ps
`default_nettype none

module capture_memory (
    input  logic                  clock,
    input  logic                  write_enable,
    input  capture_pkg::addr_t    write_address,
    input  capture_pkg::sample_t  write_data,
    input  logic                  read_enable,
    input  capture_pkg::addr_t    read_address,
    output capture_pkg::sample_t  read_data
);

    import capture_pkg::*;

    localparam int DEPTH = 1 << $bits(addr_t);

    sample_t storage [DEPTH];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            storage[write_address] <= write_data;
        end
    end

    // Output register holds its value while read_enable is low
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= storage[read_address];
        end
    end

endmodule

`default_nettype wire

// File: capture_buffer.sv
/*
 * Per-channel circular capture buffer
 * Records continuously, freezes a window around the trigger and drains it through a skid stage
 */
`timescale 1ns/1ps
`default_nettype none

module capture_buffer (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  sample_valid,
    input  capture_pkg::sample_t  sample,
    input  logic                  trigger,
    input  capture_pkg::addr_t    packet_length,
    input  capture_pkg::addr_t    trigger_point,
    output logic                  armed,
    output logic                  full,
    input  logic                  drain_ready,
    output logic                  drain_valid,
    output capture_pkg::sample_t  drain_data,
    output logic                  drain_last
);

    import capture_pkg::*;

    buffer_state_t state;

    addr_t   head;
    addr_t   fill_count;
    addr_t   read_pointer;
    addr_t   window_end;
    addr_t   window_start_next;
    addr_t   window_end_next;
    logic    read_done;

    logic    write_enable;
    logic    fetch;
    logic    accept;
    logic    skid_load;

    sample_t ram_data;
    logic    ram_valid;
    logic    ram_last;
    sample_t skid_data;
    logic    skid_valid;
    logic    skid_last;

    // The port names shadow two of the state names, so those are scoped
    assign armed = (state == capture_pkg::armed);
    assign full  = (state == capture_pkg::full) || (state == readout);

    // Every strobe is stored except while a frozen window waits or drains
    assign write_enable = sample_valid &&
                          (state == initial_fill || state == capture_pkg::armed ||
                           state == acquisition || state == refresh);

    // Window placement if the current strobe turns out to be the trigger.
    // A length of zero wraps to the full depth
    assign window_start_next = head - trigger_point;
    assign window_end_next   = window_start_next + packet_length - addr_t'(1);

    // Reads are issued whenever the skid has room, independent of drain_ready,
    // so a stall can leave one RAM word in flight that the skid must catch
    assign fetch     = (state == readout) && !read_done && !skid_valid;
    assign accept    = drain_valid && drain_ready;
    assign skid_load = !skid_valid && fetch && ram_valid && !accept;

    capture_memory u_memory (
        .clock         (clock),
        .write_enable  (write_enable),
        .write_address (head),
        .write_data    (sample),
        .read_enable   (fetch),
        .read_address  (read_pointer),
        .read_data     (ram_data)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state        <= initial_fill;
            head         <= '0;
            fill_count   <= '0;
            read_pointer <= '0;
            window_end   <= '0;
            read_done    <= 1'b1;
            ram_valid    <= 1'b0;
            ram_last     <= 1'b0;
            skid_valid   <= 1'b0;
        end else begin
            if (write_enable) begin
                head <= head + addr_t'(1);
            end

            case (state)
                initial_fill, refresh: begin
                    // A full depth of fresh samples must be in before arming
                    if (sample_valid) begin
                        if (fill_count == '1) begin
                            state      <= capture_pkg::armed;
                            fill_count <= '0;
                        end else begin
                            fill_count <= fill_count + addr_t'(1);
                        end
                    end
                end
                capture_pkg::armed: begin
                    if (trigger) begin
                        read_pointer <= window_start_next;
                        window_end   <= window_end_next;
                        // Trigger sample may already be the last one of the window
                        if (window_end_next == head) begin
                            state <= capture_pkg::full;
                        end else begin
                            state <= acquisition;
                        end
                    end
                end
                acquisition: begin
                    if (sample_valid && head == window_end) begin
                        state <= capture_pkg::full;
                    end
                end
                capture_pkg::full: begin
                    // The mux only raises our ready once it serves this channel
                    if (drain_ready) begin
                        state     <= readout;
                        read_done <= 1'b0;
                    end
                end
                readout: begin
                    if (accept && drain_last) begin
                        state      <= refresh;
                        fill_count <= '0;
                    end
                end
                default: begin
                    state <= initial_fill;
                end
            endcase

            // RAM output stage
            if (fetch) begin
                ram_valid <= 1'b1;
                ram_last  <= (read_pointer == window_end);
                if (read_pointer == window_end) begin
                    read_done <= 1'b1;
                end else begin
                    read_pointer <= read_pointer + addr_t'(1);
                end
            end else if (accept && !skid_valid) begin
                ram_valid <= 1'b0;
            end

            // Skid stage holds the older word, it always drains first
            if (skid_valid) begin
                if (accept) begin
                    skid_valid <= 1'b0;
                end
            end else if (skid_load) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (skid_load) begin
            skid_data <= ram_data;
            skid_last <= ram_last;
        end
    end

    assign drain_valid = skid_valid || ram_valid;
    assign drain_data  = skid_valid ? skid_data : ram_data;
    assign drain_last  = skid_valid ? skid_last : (ram_valid && ram_last);

endmodule

`default_nettype wire

// File: readout_mux.sv
/*
 * Readout multiplexer
 * Once every channel holds a window, drains them in channel order onto one stream
 */
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module readout_mux (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic [`CAP_CHANNELS-1:0]                    full,
    input  logic [`CAP_CHANNELS-1:0]                    drain_valid,
    input  capture_pkg::sample_t [`CAP_CHANNELS-1:0]    drain_data,
    input  logic [`CAP_CHANNELS-1:0]                    drain_last,
    output logic [`CAP_CHANNELS-1:0]                    drain_ready,
    input  logic                                        out_ready,
    output logic                                        out_valid,
    output capture_pkg::sample_t                        out_data,
    output logic                                        out_last,
    output capture_pkg::channel_t                       out_channel,
    output logic                                        capture_full
);

    import capture_pkg::*;

    typedef enum logic {
        idle,
        serve
    } mux_state_t;

    mux_state_t state;
    channel_t   current;
    logic       serving;
    logic       packet_done;

    assign serving     = (state == serve);
    assign packet_done = out_valid && out_ready && out_last;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            current <= '0;
        end else begin
            case (state)
                idle: begin
                    // All windows are frozen on the same trigger, wait for the slowest
                    if (&full) begin
                        state   <= serve;
                        current <= '0;
                    end
                end
                serve: begin
                    if (packet_done) begin
                        if (current == channel_t'(`CAP_CHANNELS - 1)) begin
                            state <= idle;
                        end else begin
                            current <= current + channel_t'(1);
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Pure forwarding, the buffer skid keeps data stable under back-pressure
    always_comb begin
        drain_ready = '0;
        if (serving) begin
            drain_ready[current] = out_ready;
        end
    end

    assign out_valid   = serving && drain_valid[current];
    assign out_data    = drain_data[current];
    assign out_last    = serving && drain_last[current];
    assign out_channel = current;

    // Buffers keep full asserted through their readout
    assign capture_full = |full;

endmodule

`default_nettype wire

// File: capture_top.sv
/*
 * Multi-channel triggered capture unit
 * Shared trigger, one circular buffer per channel and a single readout stream
 */
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module capture_top (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        sample_valid,
    input  capture_pkg::sample_t [`CAP_CHANNELS-1:0]    sample_data,
    input  capture_pkg::channel_t                       trigger_channel,
    input  capture_pkg::sample_t                        trigger_level,
    input  capture_pkg::addr_t                          packet_length,
    input  capture_pkg::addr_t                          trigger_point,
    input  logic                                        out_ready,
    output logic                                        out_valid,
    output capture_pkg::sample_t                        out_data,
    output logic                                        out_last,
    output capture_pkg::channel_t                       out_channel,
    output logic                                        capture_full
);

    import capture_pkg::*;

    logic [`CAP_CHANNELS-1:0] armed;
    logic [`CAP_CHANNELS-1:0] full;
    logic [`CAP_CHANNELS-1:0] drain_valid;
    logic [`CAP_CHANNELS-1:0] drain_last;
    logic [`CAP_CHANNELS-1:0] drain_ready;
    sample_t [`CAP_CHANNELS-1:0] drain_data;
    logic all_armed;
    logic trigger;

    // A trigger may only fire when every channel can freeze a window
    assign all_armed = &armed;

    trigger_detect u_trigger (
        .clock           (clock),
        .rst_n           (rst_n),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .trigger_channel (trigger_channel),
        .trigger_level   (trigger_level),
        .all_armed       (all_armed),
        .trigger         (trigger)
    );

    for (genvar i = 0; i < `CAP_CHANNELS; i++) begin : g_channel
        capture_buffer u_buffer (
            .clock         (clock),
            .rst_n         (rst_n),
            .sample_valid  (sample_valid),
            .sample        (sample_data[i]),
            .trigger       (trigger),
            .packet_length (packet_length),
            .trigger_point (trigger_point),
            .armed         (armed[i]),
            .full          (full[i]),
            .drain_ready   (drain_ready[i]),
            .drain_valid   (drain_valid[i]),
            .drain_data    (drain_data[i]),
            .drain_last    (drain_last[i])
        );
    end

    readout_mux u_readout (
        .clock        (clock),
        .rst_n        (rst_n),
        .full         (full),
        .drain_valid  (drain_valid),
        .drain_data   (drain_data),
        .drain_last   (drain_last),
        .drain_ready  (drain_ready),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_last     (out_last),
        .out_channel  (out_channel),
        .capture_full (capture_full)
    );

endmodule

`default_nettype wire

// File: tb_capture.sv
/*
 * Testbench for the triggered capture unit
 * Random-walk samples checked against a window model, with random output back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module tb_capture;

    import capture_pkg::*;

    localparam int DEPTH         = 1 << `CAP_ADDR_WIDTH;
    localparam int CAPTURES      = 8;
    localparam int STROBE_LIMIT  = 4000;
    localparam int READOUT_LIMIT = 4000;

    logic                        clock = 1'b0;
    logic                        rst_n;
    logic                        sample_valid;
    sample_t [`CAP_CHANNELS-1:0] sample_data;
    channel_t                    trigger_channel;
    sample_t                     trigger_level;
    addr_t                       packet_length;
    addr_t                       trigger_point;
    logic                        out_ready;
    logic                        out_valid;
    sample_t                     out_data;
    logic                        out_last;
    channel_t                    out_channel;
    logic                        capture_full;

    // Reference model state
    int       walk [`CAP_CHANNELS];
    sample_t  history [`CAP_CHANNELS][$];
    sample_t  model_prev;
    int       fill_left;
    sample_t  expected_data [$];
    channel_t expected_channel [$];
    logic     expected_last [$];

    always #50 clock = ~clock;

    capture_top dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .trigger_channel (trigger_channel),
        .trigger_level   (trigger_level),
        .packet_length   (packet_length),
        .trigger_point   (trigger_point),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_last        (out_last),
        .out_channel     (out_channel),
        .capture_full    (capture_full)
    );

    task automatic abort_run(input string message);
        $display("%s", message);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_sample(input string what, input sample_t got, input sample_t expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at %0t: %s expected %0d got %0d",
                                $time, what, expected, got));
        end
    endtask

    task automatic compare_channel(input string what, input channel_t got,
                                   input channel_t expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at %0t: %s expected %0d got %0d",
                                $time, what, expected, got));
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at %0t: %s expected %0b got %0b",
                                $time, what, expected, got));
        end
    endtask

    // Each channel wanders by up to 200 counts per strobe, bounded so crossings keep coming
    task automatic advance_samples();
        for (int ch = 0; ch < `CAP_CHANNELS; ch++) begin
            walk[ch] = walk[ch] + int'($urandom_range(400)) - 200;
            if (walk[ch] > 3000) begin
                walk[ch] = 3000;
            end
            if (walk[ch] < -3000) begin
                walk[ch] = -3000;
            end
            sample_data[ch] = sample_t'(walk[ch]);
        end
    endtask

    task automatic run_capture(input int index);
        int      length;
        int      point;
        int      trigger_index;
        int      remaining;
        int      cycles;
        logic    triggered;
        logic    done;
        logic    held;
        sample_t held_data;
        channel_t held_channel;
        logic    held_last;
        sample_t selected;

        length = int'($urandom_range(DEPTH, 1));
        if (index == 0) begin
            length = DEPTH;
        end
        point = int'($urandom_range(length - 1, 0));
        if (index == 1) begin
            point = length - 1;
        end
        packet_length   = addr_t'(length);
        trigger_point   = addr_t'(point);
        trigger_channel = channel_t'($urandom_range(`CAP_CHANNELS - 1));
        trigger_level   = sample_t'(int'($urandom_range(1000)) - 500);
        out_ready       = 1'b1;

        // Every buffer restarts its fill count here, after reset or after refresh entry
        fill_left     = DEPTH;
        triggered     = 1'b0;
        done          = 1'b0;
        remaining     = 0;
        trigger_index = 0;
        cycles        = 0;
        for (int ch = 0; ch < `CAP_CHANNELS; ch++) begin
            history[ch].delete();
        end

        while (!done) begin
            @(posedge clock);
            #1;
            compare_flag("capture_full before window complete", capture_full, 1'b0);
            compare_flag("out_valid before window complete", out_valid, 1'b0);
            compare_flag("out_last before window complete", out_last, 1'b0);
            sample_valid = ($urandom_range(3) != 0);
            if (sample_valid) begin
                advance_samples();
                selected = sample_data[trigger_channel];
                for (int ch = 0; ch < `CAP_CHANNELS; ch++) begin
                    history[ch].push_back(sample_data[ch]);
                end
                if (triggered) begin
                    remaining = remaining - 1;
                    done      = (remaining == 0);
                end else if (fill_left > 0) begin
                    fill_left = fill_left - 1;
                end else if (model_prev < trigger_level && selected >= trigger_level) begin
                    triggered     = 1'b1;
                    trigger_index = history[0].size() - 1;
                    remaining     = length - 1 - point;
                    done          = (remaining == 0);
                end
                model_prev = selected;
            end
            cycles = cycles + 1;
            if (cycles > STROBE_LIMIT) begin
                abort_run("Timeout: the capture window did not complete within the strobe limit");
            end
        end

        // Full must rise on the cycle after the last window strobe
        @(posedge clock);
        #1;
        sample_valid = 1'b0;
        compare_flag("capture_full after window complete", capture_full, 1'b1);

        expected_data.delete();
        expected_channel.delete();
        expected_last.delete();
        for (int ch = 0; ch < `CAP_CHANNELS; ch++) begin
            for (int i = 0; i < length; i++) begin
                expected_data.push_back(history[ch][trigger_index - point + i]);
                expected_channel.push_back(channel_t'(ch));
                expected_last.push_back(i == length - 1);
            end
        end

        held   = 1'b0;
        cycles = 0;
        while (expected_data.size() > 0) begin
            @(posedge clock);
            #1;
            out_ready = ($urandom_range(3) != 0);
            #1;
            if (held) begin
                compare_flag("out_valid held under back-pressure", out_valid, 1'b1);
                compare_sample("out_data held under back-pressure", out_data, held_data);
                compare_channel("out_channel held under back-pressure", out_channel,
                                held_channel);
                compare_flag("out_last held under back-pressure", out_last, held_last);
            end
            if (out_valid && out_ready) begin
                compare_sample("out_data", out_data, expected_data.pop_front());
                compare_channel("out_channel", out_channel, expected_channel.pop_front());
                compare_flag("out_last", out_last, expected_last.pop_front());
            end
            held         = out_valid && !out_ready;
            held_data    = out_data;
            held_channel = out_channel;
            held_last    = out_last;
            cycles = cycles + 1;
            if (cycles > READOUT_LIMIT) begin
                abort_run("Timeout: the readout did not deliver every expected sample");
            end
        end

        // Let the final beat transfer, then pause before strobing again
        @(posedge clock);
        #1;
        out_ready = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        compare_flag("capture_full after readout", capture_full, 1'b0);
        compare_flag("out_valid after readout", out_valid, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h144));
        rst_n           = 1'b0;
        sample_valid    = 1'b0;
        sample_data     = '0;
        trigger_channel = '0;
        trigger_level   = '0;
        packet_length   = '0;
        trigger_point   = '0;
        out_ready       = 1'b0;
        model_prev      = '0;
        for (int ch = 0; ch < `CAP_CHANNELS; ch++) begin
            walk[ch] = 0;
        end

        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        compare_flag("out_valid after reset", out_valid, 1'b0);
        compare_flag("out_last after reset", out_last, 1'b0);
        compare_flag("capture_full after reset", capture_full, 1'b0);

        for (int n = 0; n < CAPTURES; n++) begin
            run_capture(n);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
capture_pkg.sv
trigger_detect.sv
capture_memory.sv
capture_buffer.sv
readout_mux.sv
capture_top.sv
tb_capture.sv

// File: run.sh
#!/bin/sh
# Compile the capture unit testbench with Verilator and run it
# The exit status of the simulation is the exit status of this script
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_capture -f sim.f -o tb_capture

./obj_dir/tb_capture
